// File: decoderPkg.sv
package decoderPkg;

    //////////////////////////////////////////////////
    // bus types

    typedef logic [31:0] instT;
    typedef logic [31:0] addrT;
    typedef logic [31:0] immT;
    typedef logic [4:0]  regNameT;

    //////////////////////////////////////////////////
    // major opcodes of the RV32I base set

    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcAuipc  = 7'b0010111;
    localparam logic [6:0] opcJal    = 7'b1101111;
    localparam logic [6:0] opcJalr   = 7'b1100111;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcOp     = 7'b0110011;

    // internal operation codes, NOP stays at zero so a cleared packet is harmless
    typedef enum logic [5:0] {
        NOP,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
        SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND
    } opT;

    //////////////////////////////////////////////////
    // packets

    // one fetched instruction as delivered by the fetch unit
    typedef struct packed {
        instT inst;
        addrT pc;
        logic pd;       // predicted taken
    } fetchPktT;

    // decoded instruction handed to the register file
    typedef struct packed {
        regNameT rs1;
        regNameT rs2;
        regNameT rd;
        opT      op;
        addrT    pc;
        immT     imm;
        logic    pd;
    } rfPktT;

endpackage

// File: immGen.sv
`timescale 1ns/100ps

module immGen (
    input  decoderPkg::instT inst,
    output decoderPkg::immT  imm
);
    import decoderPkg::*;

    logic [6:0] opcode;
    logic       sign;

    assign opcode = inst[6:0];
    assign sign   = inst[31];   // every format keeps its sign in bit 31

    //////////////////////////////////////////////////
    // format select

    always_comb begin
        case (opcode)
            opcLui,
            opcAuipc: begin
                imm = {inst[31:12], 12'b0};
            end
            opcJal: begin
                // offset bits are scattered, lowest bit is always zero
                imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            opcBranch: begin
                imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            opcJalr,
            opcLoad,
            opcOpImm: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            opcStore: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};   // split around rd slot
            end
            default: begin
                imm = '0;   // register ALU and unsupported opcodes carry no immediate
            end
        endcase
    end

endmodule

// File: opDecode.sv
`timescale 1ns/100ps

module opDecode (
    input  decoderPkg::instT inst,
    output decoderPkg::opT   op
);
    import decoderPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign alt    = inst[30];   // selects SRAI over SRLI

    always_comb begin
        op = NOP;
        case (opcode)
            opcLui:   op = LUI;
            opcAuipc: op = AUIPC;
            opcJal:   op = JAL;
            opcJalr:  op = JALR;

            //////////////////////////////////////////////////
            // control transfer and memory

            opcBranch: begin
                case (funct3)
                    3'b000:  op = BEQ;
                    3'b001:  op = BNE;
                    3'b100:  op = BLT;
                    3'b101:  op = BGE;
                    3'b110:  op = BLTU;
                    3'b111:  op = BGEU;
                    default: op = NOP;  // 010 and 011 are reserved
                endcase
            end
            opcLoad: begin
                case (funct3)
                    3'b000:  op = LB;
                    3'b001:  op = LH;
                    3'b010:  op = LW;
                    3'b100:  op = LBU;
                    3'b101:  op = LHU;
                    default: op = NOP;
                endcase
            end
            opcStore: begin
                case (funct3)
                    3'b000:  op = SB;
                    3'b001:  op = SH;
                    3'b010:  op = SW;
                    default: op = NOP;
                endcase
            end

            //////////////////////////////////////////////////
            // integer ALU

            opcOpImm: begin
                case (funct3)
                    3'b000: op = ADDI;
                    3'b010: op = SLTI;
                    3'b011: op = SLTIU;
                    3'b100: op = XORI;
                    3'b110: op = ORI;
                    3'b111: op = ANDI;
                    3'b001: op = alt ? NOP : SLLI;
                    3'b101: op = alt ? SRAI : SRLI;
                    default: op = NOP;
                endcase
            end
            opcOp: begin
                // only funct7 0000000 and 0100000 exist in the base set, RV32M lands in NOP
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: op = ADD;
                        3'b001: op = SLL;
                        3'b010: op = SLT;
                        3'b011: op = SLTU;
                        3'b100: op = XOR;
                        3'b101: op = SRL;
                        3'b110: op = OR;
                        3'b111: op = AND;
                        default: op = NOP;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) op = SUB;
                    else if (funct3 == 3'b101) op = SRA;
                end
            end
            default: op = NOP;  // fence, system and anything unknown
        endcase
    end

endmodule

// File: dispatchStage.sv
`timescale 1ns/100ps

module dispatchStage #(
    parameter int robDepth = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rdy,
    input  logic                        fetchEn,
    input  decoderPkg::fetchPktT        fetch,
    input  decoderPkg::immT             imm,
    input  decoderPkg::opT              op,
    output logic                        rfEn,
    output decoderPkg::rfPktT           rf,
    output logic                        robEn,
    output decoderPkg::regNameT         robRd,
    output logic [$clog2(robDepth)-1:0] robTag
);
    import decoderPkg::*;

    localparam int tagW = $clog2(robDepth);

    logic            accept;
    logic [tagW-1:0] tagCnt;    // tag handed to the next accepted instruction

    assign accept = rdy && fetchEn;

    //////////////////////////////////////////////////
    // output register and tag allocation

    always_ff @(posedge clk) begin
        if (rst) begin
            rfEn   <= 1'b0;
            robEn  <= 1'b0;
            robTag <= '0;
            tagCnt <= '0;
            rf.op  <= NOP;
        end else begin
            rfEn  <= accept;    // strobes last one cycle per accepted instruction
            robEn <= accept;
            if (accept) begin
                rf.rs1 <= fetch.inst[19:15];
                rf.rs2 <= fetch.inst[24:20];
                rf.rd  <= fetch.inst[11:7];
                rf.op  <= op;
                rf.pc  <= fetch.pc;
                rf.imm <= imm;
                rf.pd  <= fetch.pd;
                robRd  <= fetch.inst[11:7];
                robTag <= tagCnt;
                // power-of-two depth, so the counter wraps by itself
                tagCnt <= tagCnt + tagW'(1);
            end
        end
    end

endmodule

// File: decoderTop.sv
`timescale 1ns/100ps

module decoderTop #(
    parameter int robDepth = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rdy,
    input  logic                        fetchEn,
    input  decoderPkg::fetchPktT        fetch,
    output logic                        rfEn,
    output decoderPkg::rfPktT           rf,
    output logic                        robEn,
    output decoderPkg::regNameT         robRd,
    output logic [$clog2(robDepth)-1:0] robTag
);
    import decoderPkg::*;

    immT imm;
    opT  op;

    // both decoders look at the same word in the same cycle
    immGen immGen_i (
        .inst (fetch.inst),
        .imm  (imm)
    );

    opDecode opDecode_i (
        .inst (fetch.inst),
        .op   (op)
    );

    dispatchStage #(
        .robDepth (robDepth)
    ) dispatchStage_i (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .fetchEn (fetchEn),
        .fetch   (fetch),
        .imm     (imm),
        .op      (op),
        .rfEn    (rfEn),
        .rf      (rf),
        .robEn   (robEn),
        .robRd   (robRd),
        .robTag  (robTag)
    );

endmodule

// File: decoderTop_assert.sv
`timescale 1ns/100ps

module decoderTopAssert #(
    parameter int robDepth = 16
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        rdy,
    input logic                        rfEn,
    input logic                        robEn,
    input logic [$clog2(robDepth)-1:0] robTag
);
    localparam int tagW = $clog2(robDepth);

    logic            seenTag;   // at least one strobe since reset
    logic [tagW-1:0] lastTag;

    always_ff @(posedge clk) begin
        if (rst) begin
            seenTag <= 1'b0;
            lastTag <= '0;
        end else if (rfEn) begin
            seenTag <= 1'b1;
            lastTag <= robTag;
        end
    end

    //////////////////////////////////////////////////
    // dispatch strobe rules

    strobesMatch: assert property (@(posedge clk) disable iff (rst) rfEn == robEn)
        else $error("rfEn and robEn differ");

    // tags of consecutive dispatches step by one and wrap at the depth
    tagStep: assert property (@(posedge clk) disable iff (rst)
        (rfEn && seenTag) |-> robTag == tagW'(lastTag + 1'b1))
        else $error("robTag did not advance by one between strobes");

    noStrobeAfterStall: assert property (@(posedge clk) disable iff (rst)
        !$past(rdy) |-> !rfEn)
        else $error("dispatch strobe in the cycle after rdy was low");

endmodule

bind decoderTop decoderTopAssert #(
    .robDepth (robDepth)
) decoderTopAssert_i (
    .clk    (clk),
    .rst    (rst),
    .rdy    (rdy),
    .rfEn   (rfEn),
    .robEn  (robEn),
    .robTag (robTag)
);

// File: decoderTb.sv
`timescale 1ns/100ps

module decoderTb;
    import decoderPkg::*;

    localparam int robDepth  = 4;     // small depth so the tag wraps early
    localparam int waitLimit = 10;

    // one row of the stimulus table
    typedef struct packed {
        instT inst;
        addrT pc;
        logic pd;
        opT   op;       // expected operation
        immT  imm;      // expected immediate
        logic stall;    // hold rdy low for a few cycles before this row
    } vecT;

    logic     clk     = 1'b0;
    logic     rst     = 1'b1;
    logic     rdy     = 1'b0;
    logic     fetchEn = 1'b0;
    fetchPktT fetch   = '0;
    logic     rfEn;
    rfPktT    rf;
    logic     robEn;
    regNameT  robRd;
    logic [$clog2(robDepth)-1:0] robTag;

    vecT   vecs[$];
    string names[$];
    int    seed = 93;
    int    errCnt = 0;
    int    failedTests = 0;
    int    testsRun = 0;
    bit    testOk;
    bit    timedOut = 1'b0;

    always #10 clk = ~clk;

    decoderTop #(
        .robDepth (robDepth)
    ) decoderTop_i (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .fetchEn (fetchEn),
        .fetch   (fetch),
        .rfEn    (rfEn),
        .rf      (rf),
        .robEn   (robEn),
        .robRd   (robRd),
        .robTag  (robTag)
    );

    //////////////////////////////////////////////////
    // helpers

    task automatic addVector(input string name, input instT inst, input addrT pc,
                             input logic pd, input opT op, input immT imm, input logic stall);
        vecT v;
        v.inst  = inst;
        v.pc    = pc;
        v.pd    = pd;
        v.op    = op;
        v.imm   = imm;
        v.stall = stall;
        vecs.push_back(v);
        names.push_back(name);
    endtask

    task automatic checkValue(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, act);
            errCnt++;
            testOk = 1'b0;
        end
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        if (testOk) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed", name);
            failedTests++;
        end
    endtask

    // immediates worked out by hand from the RV32I encodings
    task automatic loadTable();
        addVector("lui",      32'h123452B7, 32'h00001000, 1'b0, LUI,   32'h12345000, 1'b0);
        addVector("auipc",    32'hFFFFF397, 32'h00001004, 1'b0, AUIPC, 32'hFFFFF000, 1'b0);
        addVector("jalBack",  32'hFFDFF0EF, 32'h00001008, 1'b1, JAL,   32'hFFFFFFFC, 1'b0);
        addVector("jalFwd",   32'h0010006F, 32'h0000100C, 1'b1, JAL,   32'h00000800, 1'b1);
        addVector("bneBack",  32'hFEB518E3, 32'h00001010, 1'b1, BNE,   32'hFFFFFFF0, 1'b0);
        addVector("beqFwd",   32'h00208463, 32'h00001014, 1'b0, BEQ,   32'h00000008, 1'b0);
        addVector("brRsvd",   32'h0020A463, 32'h00001018, 1'b0, NOP,   32'h00000008, 1'b0);
        addVector("addiNeg",  32'hFFF30313, 32'h0000101C, 1'b0, ADDI,  32'hFFFFFFFF, 1'b1);
        addVector("xori",     32'h7FF2C213, 32'h00001020, 1'b0, XORI,  32'h000007FF, 1'b0);
        addVector("lw",       32'h00C12403, 32'h00001024, 1'b0, LW,    32'h0000000C, 1'b0);
        addVector("ldRsvd",   32'h00C13403, 32'h00001028, 1'b0, NOP,   32'h0000000C, 1'b0);
        addVector("swNeg",    32'hFE512E23, 32'h0000102C, 1'b0, SW,    32'hFFFFFFFC, 1'b1);
        addVector("stRsvd",   32'hFE513E23, 32'h00001030, 1'b0, NOP,   32'hFFFFFFFC, 1'b0);
        addVector("add",      32'h002081B3, 32'h00001034, 1'b0, ADD,   32'h00000000, 1'b0);
        addVector("sub",      32'h402081B3, 32'h00001038, 1'b0, SUB,   32'h00000000, 1'b0);
        addVector("srl",      32'h007352B3, 32'h0000103C, 1'b0, SRL,   32'h00000000, 1'b0);
        addVector("sra",      32'h407352B3, 32'h00001040, 1'b0, SRA,   32'h00000000, 1'b1);
        addVector("rRsvd",    32'h402091B3, 32'h00001044, 1'b0, NOP,   32'h00000000, 1'b0);
        addVector("slli",     32'h00311093, 32'h00001048, 1'b0, SLLI,  32'h00000003, 1'b0);
        addVector("srli",     32'h00415093, 32'h0000104C, 1'b0, SRLI,  32'h00000004, 1'b0);
        addVector("srai",     32'h40415093, 32'h00001050, 1'b0, SRAI,  32'h00000404, 1'b0);
        addVector("slliRsvd", 32'h40311093, 32'h00001054, 1'b0, NOP,   32'h00000403, 1'b1);
        addVector("jalr",     32'h010280E7, 32'h00001058, 1'b0, JALR,  32'h00000010, 1'b0);
        addVector("ecall",    32'h00000073, 32'h0000105C, 1'b0, NOP,   32'h00000000, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // stimulus and checks

    initial begin
        vecT v;
        int  stallCycles;
        int  waited;
        int  acceptedCnt;
        int  heldTag;
        acceptedCnt = 0;
        heldTag     = 0;
        loadTable();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        testOk = 1'b1;
        checkValue("reset", "rfEn", 32'd0, 32'(rfEn));
        checkValue("reset", "robEn", 32'd0, 32'(robEn));
        checkValue("reset", "robTag", 32'd0, 32'(robTag));
        checkValue("reset", "op", 32'(NOP), 32'(rf.op));
        reportTest("reset");

        for (int i = 0; i < vecs.size() && !timedOut; i++) begin
            v      = vecs[i];
            testOk = 1'b1;
            if (v.stall) begin
                stallCycles = 1 + ($unsigned($random(seed)) % 3);
                @(posedge clk);
                rdy     <= 1'b0;    // instruction offered but the core is stalled
                fetchEn <= 1'b1;
                fetch   <= {v.inst, v.pc, v.pd};
                repeat (stallCycles) begin
                    @(posedge clk);
                    @(negedge clk);
                    checkValue(names[i], "stalled rfEn", 32'd0, 32'(rfEn));
                    checkValue(names[i], "stalled robEn", 32'd0, 32'(robEn));
                    checkValue(names[i], "stalled robTag", 32'(heldTag), 32'(robTag));
                end
            end

            @(posedge clk);
            rdy     <= 1'b1;
            fetchEn <= 1'b1;
            fetch   <= {v.inst, v.pc, v.pd};
            @(posedge clk);
            fetchEn <= 1'b0;

            waited = 0;
            @(negedge clk);
            while (!rfEn && waited < waitLimit) begin
                @(negedge clk);
                waited++;
            end

            if (!rfEn) begin
                $display("no dispatch strobe arrived for %s within %0d cycles", names[i],
                         waitLimit);
                timedOut = 1'b1;
                failedTests++;
            end else begin
                checkValue(names[i], "robEn", 32'd1, 32'(robEn));
                checkValue(names[i], "op", 32'(v.op), 32'(rf.op));
                checkValue(names[i], "imm", v.imm, rf.imm);
                checkValue(names[i], "rs1", 32'(v.inst[19:15]), 32'(rf.rs1));
                checkValue(names[i], "rs2", 32'(v.inst[24:20]), 32'(rf.rs2));
                checkValue(names[i], "rd", 32'(v.inst[11:7]), 32'(rf.rd));
                checkValue(names[i], "pc", v.pc, rf.pc);
                checkValue(names[i], "pd", 32'(v.pd), 32'(rf.pd));
                checkValue(names[i], "robRd", 32'(v.inst[11:7]), 32'(robRd));
                checkValue(names[i], "robTag", 32'(acceptedCnt % robDepth), 32'(robTag));
                heldTag = acceptedCnt % robDepth;
                acceptedCnt++;
                reportTest(names[i]);
            end
        end

        $display("tests run %0d, failed %0d, check errors %0d", testsRun, failedTests, errCnt);
        if (errCnt == 0 && failedTests == 0 && !timedOut) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
decoderPkg.sv
immGen.sv
opDecode.sv
dispatchStage.sv
decoderTop.sv
decoderTop_assert.sv
decoderTb.sv

// File: Makefile
TOP = decoderTb
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
